// ==== rtl/rsa_pkg.sv ====
package rsa_pkg;

    // operand width and loop lengths
    localparam int RSA_W     = 256;
    localparam int RSA_STEPS = 256;
    localparam int RSA_CNT_W = 9;

    // index of the last multiplier bit and the last exponent bit
    localparam logic [RSA_CNT_W-1:0] RSA_LAST_BIT = RSA_CNT_W'(RSA_STEPS - 1);

    // prep counter value that marks the final accumulate pass
    localparam logic [RSA_CNT_W-1:0] RSA_PREP_END = RSA_CNT_W'(RSA_STEPS);

    typedef logic [RSA_W-1:0] rsa_word_t;

    // one spare bit for sums that may exceed N
    typedef logic [RSA_W:0] rsa_wide_t;

    // job as given at the core input
    typedef struct packed {
        rsa_word_t n;
        rsa_word_t d;
        rsa_word_t y;
    } rsa_job_t;

    // job after conversion, t = y * 2^256 mod N
    typedef struct packed {
        rsa_word_t n;
        rsa_word_t d;
        rsa_word_t t;
    } rsa_exp_job_t;

endpackage

// ==== rtl/rsa_prep.sv ====
module rsa_prep import rsa_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_start,
    input  rsa_job_t     i_job,
    output logic         o_busy,
    output rsa_exp_job_t o_prep,
    output logic         o_prep_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PREP,
        S_CALC
    } state_t;

    state_t               state_r;
    logic [RSA_CNT_W-1:0] cnt_r;
    logic                 done_r;
    logic                 last_pass;
    rsa_word_t            n_r;
    rsa_word_t            d_r;
    rsa_word_t            t_r;
    rsa_word_t            m_r;
    rsa_wide_t            n_ext;
    rsa_wide_t            dbl;
    rsa_wide_t            dbl_sub;
    rsa_wide_t            sum;
    rsa_wide_t            sum_sub;
    rsa_word_t            t_next;
    rsa_word_t            m_next;

    assign last_pass = (cnt_r == RSA_PREP_END);
    assign n_ext     = {1'b0, n_r};

    // doubling of t and the final m + t, both reduced once by N
    always_comb begin
        dbl     = {t_r, 1'b0};
        dbl_sub = dbl - n_ext;
        t_next  = (dbl >= n_ext) ? dbl_sub[RSA_W-1:0] : dbl[RSA_W-1:0];
        sum     = {1'b0, m_r} + {1'b0, t_r};
        sum_sub = sum - n_ext;
        m_next  = (sum >= n_ext) ? sum_sub[RSA_W-1:0] : sum[RSA_W-1:0];
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= S_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r <= S_PREP;
                        cnt_r   <= '0;
                    end
                end
                S_PREP: begin
                    if (last_pass) begin
                        state_r <= S_IDLE;
                        done_r  <= 1'b1;
                    end else begin
                        state_r <= S_CALC;
                    end
                end
                S_CALC: begin
                    cnt_r   <= cnt_r + 1'b1;
                    state_r <= S_PREP;
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && i_start) begin
            n_r <= i_job.n;
            d_r <= i_job.d;
            t_r <= i_job.y;
            m_r <= '0;
        end else if (state_r == S_PREP) begin
            // the multiplier 2^256 has only its top bit set
            if (last_pass) begin
                m_r <= m_next;
            end else begin
                t_r <= t_next;
            end
        end
    end

    assign o_busy      = (state_r != S_IDLE);
    assign o_prep      = '{n: n_r, d: d_r, t: m_r};
    assign o_prep_done = done_r;

endmodule

// ==== rtl/rsa_mont_mul.sv ====
module rsa_mont_mul import rsa_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_start,
    input  rsa_word_t i_a,
    input  rsa_word_t i_b,
    input  rsa_word_t i_n,
    output rsa_word_t o_p,
    output logic      o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BITS,
        S_RED
    } state_t;

    state_t               state_r;
    logic [RSA_CNT_W-1:0] cnt_r;
    logic                 done_r;
    rsa_word_t            a_r;
    rsa_word_t            b_r;
    rsa_word_t            n_r;
    rsa_word_t            p_r;
    rsa_wide_t            acc_r;
    rsa_wide_t            acc_sub;
    logic [RSA_W+1:0]     sum;

    // acc stays below 2N, so the sum before halving fits in 258 bits
    always_comb begin
        sum = {1'b0, acc_r};
        if (a_r[0]) begin
            sum = sum + {2'b00, b_r};
        end
        if (sum[0]) begin
            sum = sum + {2'b00, n_r};
        end
        acc_sub = acc_r - {1'b0, n_r};
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= S_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r <= S_BITS;
                        cnt_r   <= '0;
                    end
                end
                S_BITS: begin
                    if (cnt_r == RSA_LAST_BIT) begin
                        state_r <= S_RED;
                    end
                    cnt_r <= cnt_r + 1'b1;
                end
                S_RED: begin
                    state_r <= S_IDLE;
                    done_r  <= 1'b1;
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && i_start) begin
            a_r   <= i_a;
            b_r   <= i_b;
            n_r   <= i_n;
            acc_r <= '0;
        end else if (state_r == S_BITS) begin
            acc_r <= sum[RSA_W+1:1];
            a_r   <= a_r >> 1;
        end else if (state_r == S_RED) begin
            // single conditional subtract brings the result below N
            p_r <= (acc_r >= {1'b0, n_r}) ? acc_sub[RSA_W-1:0] : acc_r[RSA_W-1:0];
        end
    end

    assign o_p    = p_r;
    assign o_done = done_r;

endmodule

// ==== rtl/rsa_mont_exp.sv ====
module rsa_mont_exp import rsa_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_start,
    input  rsa_exp_job_t i_job,
    output logic         o_idle,
    output rsa_word_t    o_result,
    output logic         o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MSTART,
        S_MWAIT
    } state_t;

    state_t               state_r;
    logic [RSA_CNT_W-1:0] cnt_r;
    logic                 done_r;
    logic                 last_bit;
    logic                 mul_start;
    logic                 acc_done;
    logic                 sq_done;
    logic                 mul_done;
    rsa_word_t            n_r;
    rsa_word_t            d_r;
    rsa_word_t            t_r;
    rsa_word_t            m_r;
    rsa_word_t            res_r;
    rsa_word_t            prod_acc;
    rsa_word_t            prod_sq;
    rsa_word_t            m_next;

    assign mul_start = (state_r == S_MSTART);
    // both multipliers run in lockstep
    assign mul_done  = acc_done && sq_done;
    assign last_bit  = (cnt_r == RSA_LAST_BIT);
    assign m_next    = d_r[0] ? prod_acc : m_r;

    rsa_mont_mul u_mul_acc (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_a     (m_r),
        .i_b     (t_r),
        .i_n     (n_r),
        .o_p     (prod_acc),
        .o_done  (acc_done)
    );

    rsa_mont_mul u_mul_sq (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_a     (t_r),
        .i_b     (t_r),
        .i_n     (n_r),
        .o_p     (prod_sq),
        .o_done  (sq_done)
    );

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= S_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r <= S_MSTART;
                        cnt_r   <= '0;
                    end
                end
                S_MSTART: state_r <= S_MWAIT;
                S_MWAIT: begin
                    if (mul_done) begin
                        if (last_bit) begin
                            state_r <= S_IDLE;
                            done_r  <= 1'b1;
                        end else begin
                            state_r <= S_MSTART;
                            cnt_r   <= cnt_r + 1'b1;
                        end
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && i_start) begin
            n_r <= i_job.n;
            d_r <= i_job.d;
            t_r <= i_job.t;
            // m = 1 in the normal domain, so the product leaves the domain
            m_r <= RSA_W'(1);
        end else if (state_r == S_MWAIT && mul_done) begin
            m_r <= m_next;
            t_r <= prod_sq;
            d_r <= d_r >> 1;
            if (last_bit) begin
                res_r <= m_next;
            end
        end
    end

    assign o_idle   = (state_r == S_IDLE);
    assign o_result = res_r;
    assign o_done   = done_r;

endmodule

// ==== rtl/rsa_core.sv ====
module rsa_core import rsa_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_start,
    input  rsa_job_t  i_job,
    output logic      o_ready,
    output rsa_word_t o_result,
    output logic      o_done
);

    logic         prep_busy;
    logic         prep_done;
    logic         prep_start;
    logic         exp_idle;
    logic         exp_start;
    logic         ready;
    logic         pending_r;
    rsa_exp_job_t prep_job;
    rsa_exp_job_t hold_r;

    // accept only with the prep stage free and nothing waiting
    assign ready      = !prep_busy && !pending_r;
    assign prep_start = i_start && ready;
    assign exp_start  = pending_r && exp_idle;

    rsa_prep u_prep (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (prep_start),
        .i_job       (i_job),
        .o_busy      (prep_busy),
        .o_prep      (prep_job),
        .o_prep_done (prep_done)
    );

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pending_r <= 1'b0;
        end else if (prep_done) begin
            pending_r <= 1'b1;
        end else if (exp_start) begin
            pending_r <= 1'b0;
        end
    end

    // converted job waits here for the exponent stage
    always_ff @(posedge i_clk) begin
        if (prep_done) begin
            hold_r <= prep_job;
        end
    end

    rsa_mont_exp u_exp (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (exp_start),
        .i_job    (hold_r),
        .o_idle   (exp_idle),
        .o_result (o_result),
        .o_done   (o_done)
    );

    assign o_ready = ready;

endmodule

// ==== tests/rsa_core_checker.sv ====
module rsa_core_checker (
    input logic i_clk,
    input logic i_rst,
    input logic i_start,
    input logic i_ready,
    input logic i_done
);

    int fail_cnt = 0;

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge i_clk) disable iff (i_rst) i_done |=> !i_done)
        else begin
            $error("o_done high for two cycles in a row");
            fail_cnt++;
        end

    // an accepted start occupies the prep stage
    ready_drop: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_start && i_ready) |=> !i_ready)
        else begin
            $error("o_ready still high after an accepted start");
            fail_cnt++;
        end

    done_in_reset: assert property (@(posedge i_clk) i_rst |-> !i_done)
        else begin
            $error("o_done high during reset");
            fail_cnt++;
        end

endmodule

bind rsa_core rsa_core_checker u_checker (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (i_start),
    .i_ready (o_ready),
    .i_done  (o_done)
);

// ==== tests/rsa_core_tb.sv ====
module rsa_core_tb import rsa_pkg::*; ();

    localparam int TIMEOUT = 200000;

    logic      i_clk;
    logic      i_rst;
    logic      i_start;
    rsa_job_t  i_job;
    logic      o_ready;
    rsa_word_t o_result;
    logic      o_done;

    logic [31:0] lfsr;
    rsa_word_t   exp_q[$];
    int          err_cnt;
    int          done_cnt;
    int          start_cnt;
    int          abort_cnt;

    rsa_core rsa_core_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_job    (i_job),
        .o_ready  (o_ready),
        .o_result (o_result),
        .o_done   (o_done)
    );

    always #5 i_clk = ~i_clk;

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // plain square-and-multiply on 512-bit products
    function automatic rsa_word_t rsa_modexp(input rsa_word_t y, input rsa_word_t d,
                                             input rsa_word_t n);
        logic [2*RSA_W-1:0] acc;
        logic [2*RSA_W-1:0] base;
        logic [2*RSA_W-1:0] n_w;
        n_w  = {{RSA_W{1'b0}}, n};
        acc  = 1;
        base = {{RSA_W{1'b0}}, y} % n_w;
        for (int i = 0; i < RSA_W; i++) begin
            if (d[i]) begin
                acc = (acc * base) % n_w;
            end
            base = (base * base) % n_w;
        end
        return acc[RSA_W-1:0];
    endfunction

    task automatic draw_word(output rsa_word_t w);
        for (int i = 0; i < RSA_W; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[31];
        end
    endtask

    task automatic draw_job(output rsa_word_t n, output rsa_word_t d, output rsa_word_t y);
        draw_word(n);
        draw_word(d);
        draw_word(y);
        n[RSA_W-1] = 1'b1;
        n[0]       = 1'b1;
        // top bit clear keeps y below N
        y[RSA_W-1] = 1'b0;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
        $display("sim failed");
        $finish;
    endtask

    task automatic wait_ready();
        int cycles = 0;
        while (!o_ready) begin
            @(negedge i_clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                stop_on_timeout("o_ready");
            end
        end
    endtask

    task automatic wait_drained();
        int cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge i_clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                stop_on_timeout("outstanding results");
            end
        end
    endtask

    task automatic start_job(input rsa_word_t mod, input rsa_word_t ex, input rsa_word_t msg);
        wait_ready();
        i_start = 1'b1;
        i_job   = '{n: mod, d: ex, y: msg};
        exp_q.push_back(rsa_modexp(msg, ex, mod));
        start_cnt++;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic run_job(input rsa_word_t mod, input rsa_word_t ex, input rsa_word_t msg);
        start_job(mod, ex, msg);
        wait_drained();
    endtask

    // results leave in start order
    always @(negedge i_clk) begin
        rsa_word_t want;
        if (!i_rst && o_done) begin
            done_cnt++;
            assert (exp_q.size() > 0) else begin
                $display("result came out at %0t with no job outstanding", $time);
                err_cnt++;
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                assert (o_result === want) else begin
                    $display("** Error at %0t: result %h, expected %h", $time, o_result, want);
                    err_cnt++;
                end
            end
        end
    end

    initial begin
        rsa_word_t n;
        rsa_word_t d;
        rsa_word_t y;
        i_clk     = 1'b0;
        i_rst     = 1'b1;
        i_start   = 1'b0;
        i_job     = '0;
        lfsr      = 32'h234ca005;
        err_cnt   = 0;
        done_cnt  = 0;
        start_cnt = 0;
        abort_cnt = 0;
        repeat (3) @(negedge i_clk);
        i_rst = 1'b0;

        // d = 0, d = 1 and y = 0
        draw_job(n, d, y);
        run_job(n, '0, y);
        run_job(n, RSA_W'(1), y);
        run_job(n, d, '0);

        repeat (8) begin
            draw_job(n, d, y);
            run_job(n, d, y);
        end

        // second job enters prep while the first is exponentiated
        draw_job(n, d, y);
        start_job(n, d, y);
        draw_job(n, d, y);
        start_job(n, d, y);
        assert (!o_ready) else begin
            $display("o_ready high at %0t during prep of the second job", $time);
            err_cnt++;
        end

        // prep of the second job ends, its payload waits in the hold register
        repeat (2 * RSA_STEPS + 4) @(negedge i_clk);
        assert (!o_ready) else begin
            $display("o_ready high at %0t with the hold register full", $time);
            err_cnt++;
        end

        // start while the hold register is full must be ignored
        draw_job(n, d, y);
        i_start = 1'b1;
        i_job   = '{n: n, d: d, y: y};
        @(negedge i_clk);
        i_start = 1'b0;
        wait_drained();

        // reset in the middle of the exponent stage
        draw_job(n, d, y);
        start_job(n, d, y);
        wait_ready();
        repeat (1000) @(negedge i_clk);
        i_rst = 1'b1;
        exp_q.delete();
        abort_cnt++;
        repeat (3) begin
            @(negedge i_clk);
            assert (!o_done) else begin
                $display("o_done high at %0t while reset is held", $time);
                err_cnt++;
            end
        end
        i_rst = 1'b0;
        assert (o_ready) else begin
            $display("o_ready low at %0t after reset", $time);
            err_cnt++;
        end
        draw_job(n, d, y);
        run_job(n, d, y);

        assert (done_cnt == start_cnt - abort_cnt) else begin
            $display("%0d results for %0d completed jobs", done_cnt, start_cnt - abort_cnt);
            err_cnt++;
        end
        $display("errors %0d, assertion failures %0d, jobs %0d, results %0d",
                 err_cnt, rsa_core_inst.u_checker.fail_cnt, start_cnt, done_cnt);
        if (err_cnt == 0 && rsa_core_inst.u_checker.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== rsa256.f ====
rtl/rsa_pkg.sv
rtl/rsa_prep.sv
rtl/rsa_mont_mul.sv
rtl/rsa_mont_exp.sv
rtl/rsa_core.sv
tests/rsa_core_checker.sv
tests/rsa_core_tb.sv

// ==== Bender.yml ====
package:
  name: rsa256

sources:
  - rtl/rsa_pkg.sv
  - rtl/rsa_prep.sv
  - rtl/rsa_mont_mul.sv
  - rtl/rsa_mont_exp.sv
  - rtl/rsa_core.sv
  - target: test
    files:
      - tests/rsa_core_checker.sv
      - tests/rsa_core_tb.sv
